// File: sim.f
+incdir+logic
logic/isaPkg.sv
logic/busPkg.sv
logic/sequencer.sv
logic/decodeUnit.sv
logic/executeUnit.sv
logic/resultUnit.sv
logic/busMaster.sv
logic/coreTop.sv
dv/coreChecker.sv
dv/coreTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module coreTb -o coreSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/coreSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

// File: dv/coreTb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module coreTb import isaPkg::*, busPkg::*; ();

    localparam int MemWords  = 1024;
    localparam int DataBase  = 'h400;
    localparam int StoreBase = 'h800;

    logic        Clock;
    logic        rstN;
    axiLiteRspT  busRsp;
    axiLiteReqT  busReq;
    logic        halted;

    logic [31:0] mem [MemWords];
    logic [31:0] modelReg [32];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] lcgState = 32'ha92c_a953;
    int          progLen;
    int          skipCount;
    int          storeAddr;
    int          errorCount;
    bit          firstRead;

    coreTop DUT (
        .Clock(Clock), .rstN(rstN), .busRsp(busRsp), .busReq(busReq), .halted(halted)
    );

    bind coreTop coreChecker uChecker (
        .Clock(Clock), .rstN(rstN), .busReq(busReq), .busRsp(busRsp), .halted(halted)
    );

    always #2 Clock = ~Clock;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randDelay();
        logic [31:0] r;
        r = nextRandom();
        return int'(r[17:16]);
    endfunction

    // Largest r with r*r <= x found by bisection
    function automatic logic [31:0] isqrt(input logic [31:0] x);
        logic [63:0] lo;
        logic [63:0] hi;
        logic [63:0] mid;
        lo = 64'd0;
        hi = 64'd65536;
        while (hi - lo > 64'd1) begin
            mid = (lo + hi) >> 1;
            if (mid * mid <= {32'd0, x}) lo = mid;
            else hi = mid;
        end
        return lo[31:0];
    endfunction

    task automatic waitCycles(input int n);
        repeat (n) begin
            @(posedge Clock);
            #1;
        end
    endtask

    // Returns 1 when the next emitted instruction is executed, not jumped over
    function automatic bit takeLive();
        if (skipCount == 0) return 1'b1;
        skipCount--;
        return 1'b0;
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[progLen] = word;
        progLen++;
    endtask

    task automatic rOp(input logic [5:0] f, input int rd, input int rs, input int rt);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        a = modelReg[rs];
        b = modelReg[rt];
        case (f)
            ADD:     v = a + b;
            SUB:     v = a - b;
            AND:     v = a & b;
            OR:      v = a | b;
            SLT:     v = {31'd0, $signed(a) < $signed(b)};
            DIV:     v = (b == 32'd0) ? 32'hffff_ffff : a / b;
            MOD:     v = (b == 32'd0) ? a : a % b;
            SQRT:    v = isqrt(a);
            default: v = 32'd0;
        endcase
        if (takeLive() && rd != 0) modelReg[rd] = v;
        emit({6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, f});
    endtask

    task automatic addiOp(input int rt, input int rs, input logic [15:0] imm);
        if (takeLive() && rt != 0) modelReg[rt] = modelReg[rs] + {{16{imm[15]}}, imm};
        emit({ADDI, 5'(rs), 5'(rt), imm});
    endtask

    // Load of seeded data word k
    task automatic loadOp(input int rt, input int k);
        if (takeLive() && rt != 0) modelReg[rt] = mem[DataBase / 4 + k];
        emit({LW, 5'd0, 5'(rt), 16'(DataBase + k * 4)});
    endtask

    task automatic storeOp(input int rt);
        if (takeLive()) begin
            expAddr.push_back(32'(storeAddr));
            expData.push_back(modelReg[rt]);
        end
        emit({SW, 5'd0, 5'(rt), 16'(storeAddr)});
        storeAddr += 4;
    endtask

    task automatic branchOp(input int rs, input int rt, input int off);
        bit live;
        live = takeLive();
        emit({BEQ, 5'(rs), 5'(rt), 16'(off)});
        if (live && modelReg[rs] == modelReg[rt]) skipCount = off;
    endtask

    task automatic jumpOp(input bit link, input int skip);
        bit          live;
        logic [31:0] here;
        logic [31:0] target;
        live   = takeLive();
        here   = 32'(progLen * 4);
        target = here + 32'd4 + 32'(skip * 4);
        emit({link ? JAL : J, target[27:2]});
        if (live) begin
            if (link) modelReg[31] = here + 32'd4;
            skipCount = skip;
        end
    endtask

    task automatic buildProgram();
        progLen   = 0;
        skipCount = 0;
        storeAddr = StoreBase;
        for (int i = 0; i < 5; i++) loadOp(i + 1, i);
        rOp(ADD, 6, 1, 2);
        storeOp(6);
        rOp(SUB, 6, 1, 2);
        storeOp(6);
        rOp(AND, 6, 3, 4);
        storeOp(6);
        rOp(OR, 6, 3, 4);
        storeOp(6);
        rOp(SLT, 6, 1, 2);
        storeOp(6);
        rOp(SLT, 6, 2, 1);
        storeOp(6);
        addiOp(6, 1, 16'hff85);
        storeOp(6);
        // Small nonzero divisor in r7
        addiOp(7, 0, 16'h00ff);
        rOp(AND, 7, 3, 7);
        addiOp(7, 7, 16'h0001);
        rOp(DIV, 6, 1, 7);
        storeOp(6);
        rOp(MOD, 6, 1, 7);
        storeOp(6);
        rOp(DIV, 6, 1, 2);
        storeOp(6);
        rOp(DIV, 6, 1, 0);
        storeOp(6);
        rOp(MOD, 6, 2, 0);
        storeOp(6);
        rOp(SQRT, 6, 1, 0);
        storeOp(6);
        rOp(SQRT, 6, 4, 0);
        storeOp(6);
        storeOp(5);
        addiOp(8, 0, 16'h0005);
        addiOp(9, 0, 16'h0005);
        branchOp(8, 9, 1);
        storeOp(1);
        storeOp(8);
        branchOp(8, 0, 1);
        storeOp(9);
        jumpOp(1'b0, 2);
        storeOp(1);
        storeOp(2);
        storeOp(3);
        jumpOp(1'b1, 1);
        storeOp(1);
        storeOp(31);
        emit({HALT, 26'd0});
    endtask

    task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
        if (expAddr.size() == 0) begin
            $display("Unexpected extra store of %h to address %h", data, addr);
            errorCount++;
        end else begin
            if (addr != expAddr[0] || data != expData[0]) begin
                $display("ERROR: %0t store to address %h wrote %h, expected %h at address %h",
                    $time, addr, data, expData[0], expAddr[0]);
                errorCount++;
            end
            void'(expAddr.pop_front());
            void'(expData.pop_front());
        end
    endtask

    // AXI4-Lite slave with random ready and response delays
    initial begin : memoryModel
        logic [31:0] addr;
        logic [31:0] data;
        forever begin
            @(posedge Clock);
            #1;
            if (halted && (busReq.arvalid || busReq.awvalid)) begin
                $display("Bus request seen after the core halted");
                errorCount++;
            end
            if (busReq.arvalid) begin
                addr = busReq.araddr;
                if (!firstRead) begin
                    firstRead = 1'b1;
                    if (addr != 32'd0) begin
                        $display("ERROR: %0t first fetch from address %h", $time, addr);
                        errorCount++;
                    end
                end
                waitCycles(randDelay());
                busRsp.arready = 1'b1;
                waitCycles(1);
                busRsp.arready = 1'b0;
                waitCycles(randDelay());
                busRsp.rvalid = 1'b1;
                busRsp.rdata  = mem[addr[11:2]];
                waitCycles(1);
                busRsp.rvalid = 1'b0;
            end else if (busReq.awvalid) begin
                addr = busReq.awaddr;
                data = busReq.wdata;
                // Every store is a full word
                if (busReq.wstrb != 4'hf) begin
                    $display("ERROR: %0t store to address %h with byte strobes %h",
                        $time, addr, busReq.wstrb);
                    errorCount++;
                end
                waitCycles(randDelay());
                busRsp.awready = 1'b1;
                busRsp.wready  = 1'b1;
                waitCycles(1);
                busRsp.awready = 1'b0;
                busRsp.wready  = 1'b0;
                mem[addr[11:2]] = data;
                checkStore(addr, data);
                waitCycles(randDelay());
                busRsp.bvalid = 1'b1;
                waitCycles(1);
                busRsp.bvalid = 1'b0;
            end
        end
    end

    initial begin
        Clock      = 1'b0;
        rstN       = 1'b0;
        busRsp     = '0;
        errorCount = 0;
        firstRead  = 1'b0;
        for (int i = 0; i < 32; i++) modelReg[i] = 32'd0;
        for (int i = 0; i < MemWords; i++) mem[i] = 32'(i) * 32'h9e37_79b9 + 32'(i);
        for (int i = 0; i < 16; i++) mem[DataBase / 4 + i] = nextRandom();
        buildProgram();
        fork
            begin
                repeat (8 + progLen * 60) @(posedge Clock);
                $display("Core did not halt in time");
                $display("Test failed");
                $finish;
            end
        join_none
        repeat (8) @(posedge Clock);
        #1;
        rstN = 1'b1;
        while (!halted) @(posedge Clock);
        // Watch for stray requests after halt
        waitCycles(20);
        if (expAddr.size() != 0) begin
            $display("%0d expected stores never appeared, first at address %h",
                expAddr.size(), expAddr[0]);
            errorCount += expAddr.size();
        end
        $display("Checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: dv/coreChecker.sv
`timescale 1ns/1ps
`include "core_config.svh"

module coreChecker import isaPkg::*, busPkg::*; (
    input logic       Clock,
    input logic       rstN,
    input axiLiteReqT busReq,
    input axiLiteRspT busRsp,
    input logic       halted
);

    // Cycles since reset release, saturating
    logic [3:0] sinceReset;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            sinceReset <= '0;
        end else if (sinceReset != 4'hf) begin
            sinceReset <= sinceReset + 4'd1;
        end
    end

    assert property (@(posedge Clock) rstN && sinceReset < 4'(`RESET_HOLD_CYCLES)
        |-> !busReq.arvalid)
        else $error("read request issued during the reset hold period");

    assert property (@(posedge Clock) !rstN && $past(!rstN)
        |-> !(busReq.arvalid || busReq.awvalid || busReq.wvalid))
        else $error("valid signal high while reset is asserted");

    assert property (@(posedge Clock) disable iff (!rstN)
        busReq.arvalid && !busRsp.arready |=> busReq.arvalid && $stable(busReq.araddr))
        else $error("arvalid dropped or araddr changed before arready");

    assert property (@(posedge Clock) disable iff (!rstN)
        busReq.awvalid && !busRsp.awready |=> busReq.awvalid && $stable(busReq.awaddr))
        else $error("awvalid dropped or awaddr changed before awready");

    assert property (@(posedge Clock) disable iff (!rstN)
        busReq.wvalid && !busRsp.wready |=> busReq.wvalid && $stable(busReq.wdata))
        else $error("wvalid dropped or wdata changed before wready");

    // One transaction at a time
    assert property (@(posedge Clock) disable iff (!rstN)
        !(busReq.arvalid && busReq.awvalid))
        else $error("read and write requests outstanding together");

    assert property (@(posedge Clock) disable iff (!rstN)
        halted |-> !(busReq.arvalid || busReq.awvalid))
        else $error("bus request issued while halted");

endmodule

// File: logic/coreTop.sv
`timescale 1ns/1ps
`include "core_config.svh"

module coreTop import isaPkg::*, busPkg::*; (
    input  logic       Clock,
    input  logic       rstN,
    input  axiLiteRspT busRsp,
    output axiLiteReqT busReq,
    output logic       halted
);

    decodedT                decoded;
    execResultT             result;
    regWriteT               regWb;
    accessKindT             busKind;
    logic                   busStart;
    logic                   busDone;
    logic                   decodeEn;
    logic                   execStart;
    logic                   execWrite;
    logic                   regWrite;
    logic                   pcUpdate;
    logic [`DATA_WIDTH-1:0] rdata;
    logic [`DATA_WIDTH-1:0] pc;

    sequencer uSequencer (
        .Clock(Clock), .rstN(rstN), .decoded(decoded), .busDone(busDone),
        .busStart(busStart), .busKind(busKind), .loadInstr(),
        .decodeEn(decodeEn), .execStart(execStart), .execWrite(execWrite),
        .regWrite(regWrite), .pcUpdate(pcUpdate), .halted(halted)
    );

    // Bus read data doubles as the instruction register
    decodeUnit uDecode (
        .Clock(Clock), .rstN(rstN), .instr(rdata), .decodeEn(decodeEn),
        .regWb(regWb), .decoded(decoded)
    );

    executeUnit uExecute (
        .Clock(Clock), .rstN(rstN), .decoded(decoded), .execStart(execStart),
        .execWrite(execWrite), .result(result)
    );

    resultUnit uResult (
        .Clock(Clock), .rstN(rstN), .decoded(decoded), .result(result),
        .loadData(rdata), .regWrite(regWrite), .pcUpdate(pcUpdate),
        .pc(pc), .regWb(regWb)
    );

    busMaster uBusMaster (
        .Clock(Clock), .rstN(rstN), .busStart(busStart), .busKind(busKind),
        .pc(pc), .result(result), .decoded(decoded), .busRsp(busRsp),
        .busReq(busReq), .busDone(busDone), .rdata(rdata)
    );

endmodule

// File: logic/busMaster.sv
`timescale 1ns/1ps
`include "core_config.svh"

module busMaster import isaPkg::*, busPkg::*; (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic                   busStart,
    input  accessKindT             busKind,
    input  logic [`DATA_WIDTH-1:0] pc,
    input  execResultT             result,
    input  decodedT                decoded,
    input  axiLiteRspT             busRsp,
    output axiLiteReqT             busReq,
    output logic                   busDone,
    output logic [`DATA_WIDTH-1:0] rdata
);

    logic awAccepted;
    logic wAccepted;
    logic writeAccepted;

    // Address and data may be taken in either order
    assign awAccepted    = !busReq.awvalid || busRsp.awready;
    assign wAccepted     = !busReq.wvalid || busRsp.wready;
    assign writeAccepted = (busReq.awvalid || busReq.wvalid) && awAccepted && wAccepted;

    always_ff @(posedge Clock) begin
        busDone <= 1'b0;
        if (!rstN) begin
            busReq.awvalid <= 1'b0;
            busReq.wvalid  <= 1'b0;
            busReq.bready  <= 1'b0;
            busReq.arvalid <= 1'b0;
            busReq.rready  <= 1'b0;
        end else begin
            if (busStart && busKind == DATA_WRITE) begin
                busReq.awaddr  <= result.value;
                busReq.wdata   <= decoded.b;
                busReq.wstrb   <= '1;
                busReq.awvalid <= 1'b1;
                busReq.wvalid  <= 1'b1;
            end else if (busStart) begin
                busReq.araddr  <= (busKind == FETCH_READ) ? pc : result.value;
                busReq.arvalid <= 1'b1;
            end
            if (busReq.awvalid && busRsp.awready) busReq.awvalid <= 1'b0;
            if (busReq.wvalid && busRsp.wready) busReq.wvalid <= 1'b0;
            if (writeAccepted) busReq.bready <= 1'b1;
            if (busReq.bready && busRsp.bvalid) begin
                busReq.bready <= 1'b0;
                busDone       <= 1'b1;
            end
            if (busReq.arvalid && busRsp.arready) begin
                busReq.arvalid <= 1'b0;
                busReq.rready  <= 1'b1;
            end
            // Read data is held here until the next read
            if (busReq.rready && busRsp.rvalid) begin
                busReq.rready <= 1'b0;
                rdata         <= busRsp.rdata;
                busDone       <= 1'b1;
            end
        end
    end

endmodule

// File: logic/resultUnit.sv
`timescale 1ns/1ps
`include "core_config.svh"

module resultUnit import isaPkg::*; (
    input  logic                   Clock,
    input  logic                   rstN,
    input  decodedT                decoded,
    input  execResultT             result,
    input  logic [`DATA_WIDTH-1:0] loadData,
    input  logic                   regWrite,
    input  logic                   pcUpdate,
    output logic [`DATA_WIDTH-1:0] pc,
    output regWriteT               regWb
);

    logic [`DATA_WIDTH-1:0] pcPlus4;
    logic [`DATA_WIDTH-1:0] jumpTarget;
    logic [`DATA_WIDTH-1:0] branchTarget;
    logic [`DATA_WIDTH-1:0] nextPc;

    assign pcPlus4      = pc + 32'd4;
    // Upper bits come from the following instruction
    assign jumpTarget   = {pcPlus4[31:28], decoded.target, 2'b00};
    assign branchTarget = pcPlus4 + {decoded.imm[29:0], 2'b00};

    always_comb begin
        if (decoded.isJump) nextPc = jumpTarget;
        else if (decoded.isBranch && result.taken) nextPc = branchTarget;
        else nextPc = pcPlus4;
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pc <= '0;
        end else if (pcUpdate) begin
            pc <= nextPc;
        end
    end

    always_comb begin
        regWb.enable = regWrite;
        regWb.index  = decoded.dest;
        if (decoded.isLoad) regWb.data = loadData;
        else if (decoded.isJal) regWb.data = pcPlus4;
        else regWb.data = result.value;
    end

endmodule

// File: logic/executeUnit.sv
`timescale 1ns/1ps
`include "core_config.svh"

module executeUnit import isaPkg::*; (
    input  logic       Clock,
    input  logic       rstN,
    input  decodedT    decoded,
    input  logic       execStart,
    input  logic       execWrite,
    output execResultT result
);

    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] aluValue;
    logic [`DATA_WIDTH-1:0] quotient;
    logic [`DATA_WIDTH-1:0] remainder;
    logic                   startQ;
    logic                   sqrtStart;
    logic [15:0]            sqrtRoot;
    logic [15:0]            rootSrc;
    logic [15:0]            rootNext;
    logic [17:0]            sqrtRem;
    logic [17:0]            remSrc;
    logic [17:0]            remNext;
    logic [31:0]            sqrtRad;
    logic [31:0]            radSrc;
    logic [19:0]            remShift;
    logic [19:0]            trial;

    assign sqrtStart = execStart && !startQ;
    assign opB = (decoded.opcode == RTYPE || decoded.opcode == BEQ) ? decoded.b : decoded.imm;

    // Unsigned, operands stay put for the whole execute phase
    assign quotient  = (decoded.b == '0) ? '1 : decoded.a / decoded.b;
    assign remainder = (decoded.b == '0) ? decoded.a : decoded.a % decoded.b;

    // One restoring root step, two radicand bits per cycle
    always_comb begin
        remSrc   = sqrtStart ? 18'd0 : sqrtRem;
        rootSrc  = sqrtStart ? 16'd0 : sqrtRoot;
        radSrc   = sqrtStart ? decoded.a : sqrtRad;
        remShift = {remSrc, radSrc[31:30]};
        trial    = {2'b00, rootSrc, 2'b01};
        if (remShift >= trial) begin
            remNext  = 18'(remShift - trial);
            rootNext = {rootSrc[14:0], 1'b1};
        end else begin
            remNext  = remShift[17:0];
            rootNext = {rootSrc[14:0], 1'b0};
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            startQ <= 1'b0;
        end else begin
            startQ <= execStart;
        end
    end

    always_ff @(posedge Clock) begin
        if (execStart) begin
            sqrtRem  <= remNext;
            sqrtRoot <= rootNext;
            sqrtRad  <= {radSrc[29:0], 2'b00};
        end
    end

    always_comb begin
        case (decoded.funct)
            ADD:     aluValue = decoded.a + opB;
            SUB:     aluValue = decoded.a - opB;
            AND:     aluValue = decoded.a & opB;
            OR:      aluValue = decoded.a | opB;
            SLT:     aluValue = {31'b0, $signed(decoded.a) < $signed(opB)};
            DIV:     aluValue = quotient;
            MOD:     aluValue = remainder;
            SQRT:    aluValue = {16'b0, sqrtRoot};
            default: aluValue = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (execWrite) begin
            result.value <= aluValue;
            result.taken <= decoded.a == decoded.b;
        end
    end

endmodule

// File: logic/decodeUnit.sv
`timescale 1ns/1ps
`include "core_config.svh"

module decodeUnit import isaPkg::*; (
    input  logic                   Clock,
    input  logic                   rstN,
    input  logic [`DATA_WIDTH-1:0] instr,
    input  logic                   decodeEn,
    input  regWriteT               regWb,
    output decodedT                decoded
);

    logic [`DATA_WIDTH-1:0] regFile [`REG_COUNT];
    logic [RegIdxWidth-1:0] rs;
    logic [RegIdxWidth-1:0] rt;
    logic [RegIdxWidth-1:0] rd;
    opcodeT                 opcode;
    decodedT                next;

    assign opcode = opcodeT'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        next        = '0;
        next.opcode = opcode;
        // Non R-type instructions use the adder
        next.funct  = (opcode == RTYPE) ? functT'(instr[5:0]) : ADD;
        next.a      = (rs == '0) ? '0 : regFile[rs];
        next.b      = (rt == '0) ? '0 : regFile[rt];
        next.imm    = {{16{instr[15]}}, instr[15:0]};
        next.target = instr[25:0];
        case (opcode)
            RTYPE: next.dest = rd;
            ADDI:  next.dest = rt;
            LW: begin
                next.dest   = rt;
                next.isLoad = 1'b1;
            end
            SW:    next.isStore = 1'b1;
            BEQ:   next.isBranch = 1'b1;
            J:     next.isJump = 1'b1;
            JAL: begin
                next.dest   = RegIdxWidth'(`REG_COUNT - 1);
                next.isJump = 1'b1;
                next.isJal  = 1'b1;
            end
            HALT:  next.isHalt = 1'b1;
            // Unknown opcodes fall through as a write to register 0
            default: next.dest = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (regWb.enable && regWb.index != '0) begin
            regFile[regWb.index] <= regWb.data;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            decoded <= '0;
        end else if (decodeEn) begin
            decoded <= next;
        end
    end

endmodule

// File: logic/sequencer.sv
`timescale 1ns/1ps
`include "core_config.svh"

module sequencer import isaPkg::*, busPkg::*; (
    input  logic       Clock,
    input  logic       rstN,
    input  decodedT    decoded,
    input  logic       busDone,
    output logic       busStart,
    output accessKindT busKind,
    output logic       loadInstr,
    output logic       decodeEn,
    output logic       execStart,
    output logic       execWrite,
    output logic       regWrite,
    output logic       pcUpdate,
    output logic       halted
);

    typedef enum logic [3:0] {
        HOLD,
        FETCH,
        DECODE,
        EXEC,
        EXEC_WRITE,
        WB_JUMP,
        WB_STORE,
        WB_LOAD,
        WB_REG,
        STOPPED
    } stateT;

    localparam logic [4:0] HoldLast   = 5'(`RESET_HOLD_CYCLES - 1);
    localparam logic [4:0] DecodeLast = 5'(`DECODE_CYCLES - 1);

    stateT      state;
    stateT      nextState;
    logic       phaseChange;
    logic       startsBus;
    accessKindT startKind;
    logic [4:0] execCycles;
    // One counter serves reset hold, decode and execute
    logic [4:0] cycleCnt;

    function automatic logic [4:0] latencyOf(input decodedT d);
        logic [4:0] lat;
        lat = 5'd1;
        if (d.opcode == RTYPE) begin
            case (d.funct)
                DIV:     lat = 5'(`LAT_DIV);
                MOD:     lat = 5'(`LAT_MOD);
                SQRT:    lat = 5'(`LAT_SQRT);
                default: lat = 5'd1;
            endcase
        end
        return lat;
    endfunction

    assign execCycles = latencyOf(decoded);

    always_comb begin
        nextState = state;
        case (state)
            HOLD:       if (cycleCnt == HoldLast) nextState = FETCH;
            FETCH:      if (busDone) nextState = DECODE;
            DECODE:     if (cycleCnt == DecodeLast) nextState = EXEC;
            EXEC:       if (cycleCnt == execCycles - 5'd1) nextState = EXEC_WRITE;
            EXEC_WRITE: begin
                // HALT is caught here, after its execute cycle
                if (decoded.isHalt) nextState = STOPPED;
                else if (decoded.isJump || decoded.isBranch) nextState = WB_JUMP;
                else if (decoded.isStore) nextState = WB_STORE;
                else if (decoded.isLoad) nextState = WB_LOAD;
                else nextState = WB_REG;
            end
            WB_JUMP,
            WB_REG:     nextState = FETCH;
            WB_STORE:   if (busDone) nextState = FETCH;
            WB_LOAD:    if (busDone) nextState = WB_REG;
            default:    nextState = STOPPED;
        endcase
    end

    assign phaseChange = nextState != state;

    // Phases that open with a bus request
    always_comb begin
        startsBus = 1'b1;
        startKind = FETCH_READ;
        case (nextState)
            FETCH:    startKind = FETCH_READ;
            WB_STORE: startKind = DATA_WRITE;
            WB_LOAD:  startKind = DATA_READ;
            default:  startsBus = 1'b0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            state    <= HOLD;
            cycleCnt <= '0;
            busStart <= 1'b0;
        end else begin
            state    <= nextState;
            cycleCnt <= phaseChange ? 5'd0 : cycleCnt + 5'd1;
            busStart <= phaseChange && startsBus;
        end
    end

    always_ff @(posedge Clock) begin
        if (phaseChange) begin
            busKind <= startKind;
        end
    end

    assign loadInstr = state == FETCH;
    assign decodeEn  = state == DECODE;
    assign execStart = state == EXEC;
    assign execWrite = state == EXEC_WRITE;
    // Link register is written in the jump writeback cycle
    assign regWrite  = (state == WB_REG) || (state == WB_JUMP && decoded.isJal);
    assign pcUpdate  = (state == WB_JUMP) || (state == WB_REG) || (state == WB_STORE && busDone);
    assign halted    = state == STOPPED;

endmodule

// File: logic/busPkg.sv
`include "core_config.svh"

package busPkg;

    localparam int StrbWidth = `DATA_WIDTH / 8;

    // What the sequencer asks the bus master to do
    typedef enum logic [1:0] {
        FETCH_READ = 2'd0,
        DATA_READ  = 2'd1,
        DATA_WRITE = 2'd2
    } accessKindT;

    // Master to slave side of AXI4-Lite
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] awaddr;
        logic                   awvalid;
        logic [`DATA_WIDTH-1:0] wdata;
        logic [StrbWidth-1:0]   wstrb;
        logic                   wvalid;
        logic                   bready;
        logic [`DATA_WIDTH-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axiLiteReqT;

    // Slave to master side
    typedef struct packed {
        logic                   awready;
        logic                   wready;
        logic                   bvalid;
        logic [1:0]             bresp;
        logic                   arready;
        logic                   rvalid;
        logic [`DATA_WIDTH-1:0] rdata;
        logic [1:0]             rresp;
    } axiLiteRspT;

endpackage

// File: logic/isaPkg.sv
`include "core_config.svh"

package isaPkg;

    localparam int RegIdxWidth = $clog2(`REG_COUNT);

    // Primary opcode, instruction bits 31:26
    typedef enum logic [5:0] {
        RTYPE = 6'h00,
        J     = 6'h02,
        JAL   = 6'h03,
        BEQ   = 6'h04,
        ADDI  = 6'h08,
        LW    = 6'h23,
        SW    = 6'h2b,
        HALT  = 6'h3f
    } opcodeT;

    // Function code of R-type instructions, bits 5:0
    typedef enum logic [5:0] {
        SQRT = 6'h03,
        DIV  = 6'h04,
        MOD  = 6'h05,
        ADD  = 6'h20,
        SUB  = 6'h22,
        AND  = 6'h24,
        OR   = 6'h25,
        SLT  = 6'h2a
    } functT;

    typedef struct packed {
        opcodeT                  opcode;
        functT                   funct;
        logic [`DATA_WIDTH-1:0]  a;
        logic [`DATA_WIDTH-1:0]  b;
        logic [`DATA_WIDTH-1:0]  imm;
        logic [25:0]             target;
        logic [RegIdxWidth-1:0]  dest;
        logic                    isLoad;
        logic                    isStore;
        logic                    isJal;
        logic                    isJump;
        logic                    isBranch;
        logic                    isHalt;
    } decodedT;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] value;
        logic                   taken;
    } execResultT;

    typedef struct packed {
        logic                   enable;
        logic [RegIdxWidth-1:0] index;
        logic [`DATA_WIDTH-1:0] data;
    } regWriteT;

endpackage

// File: logic/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Word and address width
`define DATA_WIDTH 32

// Register file size, register 0 reads as zero
`define REG_COUNT 32

// Fixed phase lengths in cycles
`define DECODE_CYCLES 2
`define RESET_HOLD_CYCLES 3

// Execute cycles of the long operations, all others take one
`define LAT_DIV 7
`define LAT_MOD 9
`define LAT_SQRT 16

`endif
